// File: sram_pkg.sv
package sram_pkg;

  // the system address is split into a bank select field on top
  // and a chip-local word address below it
  localparam int bank_bits = 2;

  // one external chip per bank select code
  localparam int bank_count = 1 << bank_bits;

  // each chip holds 256k words
  localparam int local_addr_bits = 18;

  // the full address seen on the request port
  localparam int sys_addr_bits = bank_bits + local_addr_bits;

  // the same address word seen two ways
  // the input register loads it flat and the steering logic
  // reads the bank and local fields out of it
  typedef union packed {
    logic [sys_addr_bits-1:0] flat;
    struct packed {
      // selects which chip sees the request
      logic [bank_bits-1:0] bank;
      // word address passed to that chip
      logic [local_addr_bits-1:0] local_addr;
    } fields;
  } sys_addr_u;

endpackage

// File: sram_req_if.sv
interface sram_req_if #(
  parameter int data_bits = 16
);

  import sram_pkg::*;

  // request strobe, only ever high on the bank that was selected
  logic req;
  // high for a write, low for a read
  logic write_enable;
  // chip-local word address, fanned out to every bank
  logic [local_addr_bits-1:0] addr;
  // write word, fanned out to every bank
  logic [data_bits-1:0] write_data;
  // the bank can take a request at the next rising edge
  logic ready;

  // the dispatcher side drives the request and watches ready
  modport host (
    output req, write_enable, addr, write_data,
    input ready
  );

  // the controller side takes the request and drives ready
  modport bank (
    input req, write_enable, addr, write_data,
    output ready
  );

endinterface

// File: sram_bank_dispatch.sv
module sram_bank_dispatch #(
  parameter int data_bits = 16
) (
  input logic clk,
  input logic reset,
  input logic req,
  input logic write_enable,
  input sram_pkg::sys_addr_u addr,
  input logic [data_bits-1:0] write_data,
  output logic ready,
  sram_req_if.host banks [sram_pkg::bank_count]
);

  import sram_pkg::*;

  // one-stage input register in front of the fan-out
  logic req_r;
  logic write_enable_r;
  sys_addr_u addr_r;
  logic [data_bits-1:0] write_data_r;

  // ready of every bank, gathered so it can be indexed by the bank field
  logic [bank_count-1:0] bank_ready;

  // the register only moves when the bank it currently points at can take
  // the held request, so the register and that bank stall together
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      req_r <= 1'b0;
      write_enable_r <= 1'b0;
      addr_r.flat <= '0;
      write_data_r <= '0;
    end else if (ready) begin
      req_r <= req;
      write_enable_r <= write_enable;
      addr_r.flat <= addr.flat;
      write_data_r <= write_data;
    end
  end

  // address, data and direction go to all banks
  // only the chosen bank sees req, so every other bank drops back to idle
  for (genvar i = 0; i < bank_count; i++) begin : g_bank
    assign banks[i].req = req_r && (addr_r.fields.bank == bank_bits'(i));
    assign banks[i].write_enable = write_enable_r;
    assign banks[i].addr = addr_r.fields.local_addr;
    assign banks[i].write_data = write_data_r;
    assign bank_ready[i] = banks[i].ready;
  end

  // flow control follows the bank that the held request is aimed at
  assign ready = bank_ready[addr_r.fields.bank];

endmodule

// File: sram_bank_controller.sv
module sram_bank_controller #(
  parameter int data_bits = 16
) (
  input logic clk,
  input logic reset,
  sram_req_if.bank host,
  output logic reading,
  output logic [data_bits-1:0] bank_read_data,
  output logic [sram_pkg::local_addr_bits-1:0] sram_addr,
  output logic we_n,
  output logic oe_n,
  output logic ce_n,
  inout wire [data_bits-1:0] sram_data
);

  // fsm state codes
  localparam logic [2:0] st_idle = 3'd0;
  localparam logic [2:0] st_reading = 3'd1;
  localparam logic [2:0] st_read_to_write = 3'd2;
  localparam logic [2:0] st_writing = 3'd3;
  localparam logic [2:0] st_write_hold = 3'd4;

  logic [2:0] state;
  logic [2:0] next_state;
  logic [data_bits-1:0] write_data_r;
  logic accept;
  logic bus_active;

  // the turnaround clock is counted as part of the write, so a request
  // arriving then is held off instead of overwriting the pending address
  assign host.ready = (state != st_read_to_write) && (state != st_writing);
  assign accept = host.req && host.ready;

  // next state from the request that is on the port this cycle
  // with req low the bank falls back to idle and releases the chip
  always_comb begin
    next_state = state;
    case (state)
      st_idle, st_write_hold: begin
        if (!host.req) next_state = st_idle;
        else if (host.write_enable) next_state = st_writing;
        else next_state = st_reading;
      end
      st_reading: begin
        if (!host.req) next_state = st_idle;
        else if (host.write_enable) next_state = st_read_to_write;
        else next_state = st_reading;
      end
      // the chip needs a clock to let go of the bus after oe_n rises
      st_read_to_write: next_state = st_writing;
      st_writing: next_state = st_write_hold;
      default: next_state = st_idle;
    endcase
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      state <= st_idle;
    end else begin
      state <= next_state;
    end
  end

  // address and write word are only loaded on an accepted request
  // because other banks' traffic is fanned out on the same wires
  always_ff @(posedge clk) begin
    if (accept) begin
      sram_addr <= host.addr;
      write_data_r <= host.write_data;
    end
  end

  // we_n moves on the falling edge, half a clock after address and data
  // have settled, and rises again half way through the hold clock
  always_ff @(negedge clk or posedge reset) begin
    if (reset) begin
      we_n <= 1'b1;
    end else begin
      we_n <= (state != st_writing);
    end
  end

  // the chip is only enabled while it has work, which saves power when idle
  assign ce_n = (state == st_idle);
  assign oe_n = (state != st_reading);
  assign reading = (state == st_reading);

  // we drive the bus only in the two write clocks, never during turnaround
  assign bus_active = (state == st_writing) || (state == st_write_hold);
  assign sram_data = bus_active ? write_data_r : {data_bits{1'bz}};

  // zero when idle so the collector sees a clean word from silent banks
  assign bank_read_data = reading ? sram_data : '0;

endmodule

// File: sram_read_collect.sv
module sram_read_collect #(
  parameter int data_bits = 16
) (
  input logic clk,
  input logic reset,
  input logic [sram_pkg::bank_count-1:0] reading,
  input logic [sram_pkg::bank_count-1:0][data_bits-1:0] bank_read_data,
  output logic [data_bits-1:0] read_data,
  output logic read_valid
);

  import sram_pkg::*;

  // word from whichever bank holds oe this cycle
  logic [data_bits-1:0] selected;

  // at most one bank reads in a cycle since only one request is taken
  // per clock, so a plain priority pick is enough
  always_comb begin
    selected = '0;
    for (int i = 0; i < bank_count; i++) begin
      if (reading[i]) begin
        selected = bank_read_data[i];
      end
    end
  end

  // valid is a single clock pulse per read cycle of a bank
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      read_valid <= 1'b0;
    end else begin
      read_valid <= |reading;
    end
  end

  // the word is captured at the edge that ends the read clock
  always_ff @(posedge clk) begin
    if (|reading) begin
      read_data <= selected;
    end
  end

endmodule

// File: sram_multibank.sv
module sram_multibank #(
  parameter int data_bits = 16
) (
  input logic clk,
  input logic reset,
  input logic req,
  input logic write_enable,
  input logic [sram_pkg::sys_addr_bits-1:0] addr,
  input logic [data_bits-1:0] write_data,
  output logic ready,
  output logic [data_bits-1:0] read_data,
  output logic read_valid,
  output logic [sram_pkg::bank_count-1:0][sram_pkg::local_addr_bits-1:0] sram_addr,
  output logic [sram_pkg::bank_count-1:0] sram_we_n,
  output logic [sram_pkg::bank_count-1:0] sram_oe_n,
  output logic [sram_pkg::bank_count-1:0] sram_ce_n,
  inout wire [sram_pkg::bank_count-1:0][data_bits-1:0] sram_data
);

  import sram_pkg::*;

  // one request path per bank
  sram_req_if #(.data_bits(data_bits)) bank_req [bank_count] ();

  // per bank read flag and bus word into the collector
  logic [bank_count-1:0] reading;
  logic [bank_count-1:0][data_bits-1:0] bank_read_data;

  // registers the request and steers it to the addressed bank
  sram_bank_dispatch #(
    .data_bits(data_bits)
  ) sram_bank_dispatch_i (
    .clk(clk),
    .reset(reset),
    .req(req),
    .write_enable(write_enable),
    .addr(addr),
    .write_data(write_data),
    .ready(ready),
    .banks(bank_req)
  );

  // one controller per external chip
  for (genvar i = 0; i < bank_count; i++) begin : g_bank
    sram_bank_controller #(
      .data_bits(data_bits)
    ) sram_bank_controller_i (
      .clk(clk),
      .reset(reset),
      .host(bank_req[i]),
      .reading(reading[i]),
      .bank_read_data(bank_read_data[i]),
      .sram_addr(sram_addr[i]),
      .we_n(sram_we_n[i]),
      .oe_n(sram_oe_n[i]),
      .ce_n(sram_ce_n[i]),
      .sram_data(sram_data[i])
    );
  end

  // merges the banks' reads onto the single read port
  sram_read_collect #(
    .data_bits(data_bits)
  ) sram_read_collect_i (
    .clk(clk),
    .reset(reset),
    .reading(reading),
    .bank_read_data(bank_read_data),
    .read_data(read_data),
    .read_valid(read_valid)
  );

endmodule

// File: sram_chip_model.sv
module sram_chip_model #(
  parameter int data_bits = 16
) (
  input logic ce_n,
  input logic oe_n,
  input logic we_n,
  input logic [sram_pkg::local_addr_bits-1:0] addr,
  inout wire [data_bits-1:0] data,
  output logic contention
);

  timeunit 1ns;
  timeprecision 100ps;

  import sram_pkg::*;

  // whole chip array, one word per local address
  logic [data_bits-1:0] mem [1 << local_addr_bits];

  // the chip puts a word on the bus
  logic driving;

  // we-controlled write cycle, the word is taken when we_n rises
  always @(posedge we_n) begin
    if (!ce_n) begin
      mem[addr] <= data;
    end
  end

  // output enable only works while the chip is selected and not writing
  assign driving = !ce_n && !oe_n && we_n;
  assign data = driving ? mem[addr] : {data_bits{1'bz}};

  // output enable and write enable low together means the chip and the
  // controller both think they own the bus
  // a second driver while the chip reads shows up as a bus word that is
  // not the one the chip puts out
  assign contention = (!ce_n && !oe_n && !we_n) || (driving && (data !== mem[addr]));

endmodule

// File: tb_sram_multibank.sv
module tb_sram_multibank;

  timeunit 1ns;
  timeprecision 100ps;

  import sram_pkg::*;

  localparam int data_bits = 16;
  // test lengths, the cycle limit follows from them
  localparam int n_idle = 3;
  localparam int n_rand = 32;
  localparam int n_bp = 8;
  localparam int n_turn = 4;
  localparam int drain = 10;
  localparam int total_ops = 8 * (1 + n_idle) + 2 * n_rand + 2 * n_bp + 3 * n_turn
    + (bank_count + n_rand + n_bp) + drain;
  localparam int cycle_limit = 4 * total_ops + 50;

  logic clk = 1'b0;
  logic reset;
  logic req;
  logic write_enable;
  logic [sys_addr_bits-1:0] addr;
  logic [data_bits-1:0] write_data;
  logic ready;
  logic [data_bits-1:0] read_data;
  logic read_valid;
  logic [bank_count-1:0][local_addr_bits-1:0] sram_addr;
  logic [bank_count-1:0] sram_we_n;
  logic [bank_count-1:0] sram_oe_n;
  logic [bank_count-1:0] sram_ce_n;
  logic [bank_count-1:0] contention;
  wire [bank_count-1:0][data_bits-1:0] sram_data;

  integer seed;
  int cycles = 0;
  // reference memory by system address, and the words that reads must return
  logic [data_bits-1:0] ref_mem [bit [sys_addr_bits-1:0]];
  logic [data_bits-1:0] exp_q [$];
  logic [sys_addr_bits-1:0] written [$];

  // the request sitting in the dispatcher's input register
  logic held_req;
  logic held_we;
  logic [bank_bits-1:0] held_bank;
  logic [local_addr_bits-1:0] held_local;
  // local address of the request that a bank took at the last edge
  logic [local_addr_bits-1:0] taken_local;
  logic take;
  logic taken_read;
  logic exp_valid;
  logic [data_bits-1:0] exp_data;
  // per bank, read taken last edge, delayed write strobe and recent activity
  logic [bank_count-1:0] read_prev;
  logic [bank_count-1:0] we_pend;
  logic [bank_count-1:0] exp_we_low;
  logic [bank_count-1:0][3:0] took_hist;

  always #20 clk = ~clk;

  sram_multibank #(
    .data_bits(data_bits)
  ) sram_multibank_i (
    .clk(clk),
    .reset(reset),
    .req(req),
    .write_enable(write_enable),
    .addr(addr),
    .write_data(write_data),
    .ready(ready),
    .read_data(read_data),
    .read_valid(read_valid),
    .sram_addr(sram_addr),
    .sram_we_n(sram_we_n),
    .sram_oe_n(sram_oe_n),
    .sram_ce_n(sram_ce_n),
    .sram_data(sram_data)
  );

  task automatic stop_run(input string msg);
    $display("%s", msg);
    $display("Regression failed");
    $fatal(1, "run stopped at the first error");
  endtask

  for (genvar b = 0; b < bank_count; b++) begin : g_chip
    sram_chip_model #(
      .data_bits(data_bits)
    ) sram_chip_model_i (
      .ce_n(sram_ce_n[b]),
      .oe_n(sram_oe_n[b]),
      .we_n(sram_we_n[b]),
      .addr(sram_addr[b]),
      .data(sram_data[b]),
      .contention(contention[b])
    );

    // one we_n pulse per write, on this bank only, a clock late after a read
    assert property (@(posedge clk) disable iff (reset) sram_we_n[b] == ~exp_we_low[b])
      else stop_run($sformatf("FAILED at %0t ns: bank %0d we_n is %b", $time, b,
        $sampled(sram_we_n[b])));
    // oe_n is low for exactly the clock after this bank takes a read
    assert property (@(posedge clk) disable iff (reset) sram_oe_n[b] == ~read_prev[b])
      else stop_run($sformatf("FAILED at %0t ns: bank %0d oe_n is %b", $time, b,
        $sampled(sram_oe_n[b])));
    // the chip is enabled right after a request to it and never without one
    assert property (@(posedge clk) disable iff (reset)
        took_hist[b][0] ? !sram_ce_n[b] : (sram_ce_n[b] || took_hist[b] != '0))
      else stop_run($sformatf("FAILED at %0t ns: bank %0d ce_n is %b", $time, b,
        $sampled(sram_ce_n[b])));
    // the bank that took a request shows its local address on the chip pins
    assert property (@(posedge clk) disable iff (reset)
        took_hist[b][0] |-> sram_addr[b] == taken_local)
      else stop_run($sformatf("FAILED at %0t ns: bank %0d address is %h, expected %h",
        $time, b, $sampled(sram_addr[b]), $sampled(taken_local)));
    assert property (@(posedge clk) disable iff (reset) !contention[b])
      else stop_run($sformatf("bank %0d data bus was driven from both sides at once", b));
  end

  function automatic logic [sys_addr_bits-1:0] pick_addr(input logic [bank_bits-1:0] bank);
    logic [31:0] r;
    r = $random(seed);
    return {bank, r[local_addr_bits-1:0]};
  endfunction

  function automatic logic [data_bits-1:0] pick_data();
    logic [31:0] r;
    r = $random(seed);
    return r[data_bits-1:0];
  endfunction

  // holds the request until an edge with ready high takes it
  // ready only depends on registered state so the falling edge shows its value
  task automatic send_request(input logic we, input logic [sys_addr_bits-1:0] a,
                              input logic [data_bits-1:0] d);
    logic taken;
    req = 1'b1;
    write_enable = we;
    addr = a;
    write_data = d;
    taken = 1'b0;
    while (!taken) begin
      @(negedge clk);
      taken = ready;
      if (taken && we) ref_mem[a] = d;
      if (taken && !we) exp_q.push_back(ref_mem[a]);
      @(posedge clk);
      #2;
    end
  endtask

  task automatic idle_cycles(input int n);
    req = 1'b0;
    write_enable = 1'b0;
    repeat (n) begin
      @(posedge clk);
      #2;
    end
  endtask

  // the held request goes to its bank at every edge where ready is high
  assign take = held_req && ready;

  always @(posedge clk or posedge reset) begin
    if (reset) begin
      held_req <= 1'b0;
      held_we <= 1'b0;
      held_bank <= '0;
      held_local <= '0;
      taken_local <= '0;
      taken_read <= 1'b0;
      exp_valid <= 1'b0;
      exp_data <= '0;
      read_prev <= '0;
      we_pend <= '0;
      exp_we_low <= '0;
      took_hist <= '0;
    end else begin
      if (ready) begin
        held_req <= req;
        held_we <= write_enable;
        held_bank <= addr[sys_addr_bits-1 -: bank_bits];
        held_local <= addr[local_addr_bits-1:0];
      end
      if (take) taken_local <= held_local;
      // a read holds oe for one clock and is registered at its end
      taken_read <= take && !held_we;
      exp_valid <= taken_read;
      if (taken_read) exp_data <= exp_q.pop_front();
      for (int b = 0; b < bank_count; b++) begin
        logic hit;
        hit = take && (held_bank == bank_bits'(b));
        took_hist[b] <= {took_hist[b][2:0], hit};
        read_prev[b] <= hit && !held_we;
        // a write straight after a read waits one turnaround clock
        we_pend[b] <= hit && held_we && read_prev[b];
        exp_we_low[b] <= (hit && held_we && !read_prev[b]) || we_pend[b];
      end
    end
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles >= cycle_limit) stop_run($sformatf("timeout after %0d cycles", cycles));
  end

  assert property (@(posedge clk) $fell(reset) |->
      (&sram_oe_n && &sram_we_n && &sram_ce_n && !read_valid && ready))
    else stop_run($sformatf("FAILED at %0t ns: outputs not idle after reset", $time));
  // ready drops while the held request's bank turns its bus around or is in its write clock
  assert property (@(posedge clk) disable iff (reset)
      ready == !(exp_we_low[held_bank] || we_pend[held_bank]))
    else stop_run($sformatf("FAILED at %0t ns: ready is %b", $time, $sampled(ready)));
  assert property (@(posedge clk) disable iff (reset) read_valid == exp_valid)
    else stop_run($sformatf("FAILED at %0t ns: read_valid is %b, expected %b", $time,
      $sampled(read_valid), $sampled(exp_valid)));
  assert property (@(posedge clk) disable iff (reset) exp_valid |-> read_data == exp_data)
    else stop_run($sformatf("FAILED at %0t ns: read_data is %h, expected %h", $time,
      $sampled(read_data), $sampled(exp_data)));

  initial begin
    logic [sys_addr_bits-1:0] a;
    seed = 75;
    reset = 1'b1;
    req = 1'b0;
    write_enable = 1'b0;
    addr = '0;
    write_data = '0;
    repeat (3) @(posedge clk);
    #2 reset = 1'b0;
    // one isolated write and read per bank, so each shows on its own pins
    for (int b = 0; b < bank_count; b++) begin
      a = pick_addr(bank_bits'(b));
      send_request(1'b1, a, pick_data());
      idle_cycles(n_idle);
      send_request(1'b0, a, '0);
      idle_cycles(n_idle);
      written.push_back(a);
    end
    // random writes over all banks, then read back in the same order
    for (int i = 0; i < n_rand; i++) begin
      a = pick_addr(bank_bits'($random(seed)));
      send_request(1'b1, a, pick_data());
      written.push_back(a);
    end
    for (int i = 0; i < n_rand; i++) send_request(1'b0, written[bank_count + i], '0);
    // back to back writes into bank 2 stall for a clock each
    for (int i = 0; i < n_bp; i++) begin
      a = pick_addr(bank_bits'(2));
      send_request(1'b1, a, pick_data());
      written.push_back(a);
    end
    for (int i = 0; i < n_bp; i++) send_request(1'b0, written[bank_count + n_rand + i], '0);
    // read then overwrite the same word, then read the new word
    for (int i = 0; i < n_turn; i++) begin
      a = written[i];
      send_request(1'b0, a, '0);
      send_request(1'b1, a, pick_data());
      send_request(1'b0, a, '0);
    end
    // one long read stream that hops between banks
    for (int i = 0; i < written.size(); i++) send_request(1'b0, written[i], '0);
    idle_cycles(drain);
    if (exp_q.size() == 0) begin
      $display("Regression passed");
      $finish;
    end else begin
      stop_run($sformatf("%0d reads never returned data", exp_q.size()));
    end
  end

endmodule

// File: tb.f
sram_pkg.sv
sram_req_if.sv
sram_bank_dispatch.sv
sram_bank_controller.sv
sram_read_collect.sv
sram_multibank.sv
sram_chip_model.sv
tb_sram_multibank.sv

// File: Makefile
VERILATOR ?= verilator
TOP ?= tb_sram_multibank
FILELIST ?= tb.f
OBJ_DIR ?= obj_dir
VFLAGS ?= --binary --assert --timescale 1ns/1ps -j 0

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	@out="$$($(SIM))"; echo "$$out"; echo "$$out" | grep -qx "Regression passed"

clean:
	rm -rf $(OBJ_DIR)
